// File: filelist.f
src/mips_pkg.sv
src/decoded_if.sv
src/inst_fetch.sv
src/inst_decode.sv
src/alu_execute.sv
src/wb_result.sv
src/reg_file.sv
src/mips_core.sv
dv/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - src/mips_pkg.sv
  - src/decoded_if.sv
  - src/inst_fetch.sv
  - src/inst_decode.sv
  - src/alu_execute.sv
  - src/wb_result.sv
  - src/reg_file.sv
  - src/mips_core.sv
  - target: simulation
    files:
      - dv/mips_core_tb.sv

// File: dv/mips_core_tb.sv
// Testbench for the MIPS32 core: clock, reset, instruction and data bus models,
// program and expected retirement trace, trace checks and watchdog
module mips_core_tb;

    localparam logic [31:0] boot_pc       = 32'hbfc00000;
    localparam int          num_rows      = 28;
    localparam int          rom_words     = 64;
    localparam int          ram_words     = 64;
    localparam int          watchdog_time = (num_rows * 20 + 50) * 4;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] pc;
        logic [3:0]  wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_row_t;

    logic        clk;
    logic        rst;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    logic        data_req;
    logic        data_wr;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_addr_ok;
    logic        data_data_ok;
    logic [31:0] data_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    trace_row_t  rows [num_rows];
    logic [31:0] rom [rom_words];
    logic [31:0] ram [ram_words];
    logic [31:0] lcg_state = 32'hd5e3a904;
    int          row_errors;

    mips_core #(.reset_pc(boot_pc)) mips_core_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16] % n;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5aa5a5;
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] funct);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] jump_to(input logic [31:0] target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic logic [31:0] rom_read(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - boot_pc;
        if (offset < rom_words * 4) return rom[offset[7:2]];
        return fill_word(addr);
    endfunction

    task automatic fill_table();
        rows[0]  = '{i_type('h0f, 0, 1, 'h1234), 'hbfc00000, 'hf, 1, 'h12340000};  // LUI
        rows[1]  = '{i_type('h0d, 1, 1, 'h8765), 'hbfc00004, 'hf, 1, 'h12348765};
        rows[2]  = '{i_type('h09, 0, 2, 'hfffd), 'hbfc00008, 'hf, 2, 'hfffffffd};
        rows[3]  = '{i_type('h0c, 2, 3, 'hf0f0), 'hbfc0000c, 'hf, 3, 'h0000f0f0};
        rows[4]  = '{i_type('h0e, 1, 4, 'hffff), 'hbfc00010, 'hf, 4, 'h1234789a};
        rows[5]  = '{i_type('h0b, 1, 5, 'hffff), 'hbfc00014, 'hf, 5, 'h00000001};
        rows[6]  = '{i_type('h09, 1, 0, 'h0005), 'hbfc00018, 'h0, 0, 'h0};  // Write to r0
        rows[7]  = '{r_type(1, 2, 6, 0, 'h21), 'hbfc0001c, 'hf, 6, 'h12348762};
        rows[8]  = '{r_type(3, 1, 7, 0, 'h23), 'hbfc00020, 'hf, 7, 'hedcc698b};
        rows[9]  = '{r_type(1, 4, 8, 0, 'h24), 'hbfc00024, 'hf, 8, 'h12340000};
        rows[10] = '{r_type(3, 2, 9, 0, 'h25), 'hbfc00028, 'hf, 9, 'hfffffffd};
        rows[11] = '{r_type(1, 4, 10, 0, 'h26), 'hbfc0002c, 'hf, 10, 'h0000ffff};
        rows[12] = '{r_type(3, 0, 11, 0, 'h27), 'hbfc00030, 'hf, 11, 'hffff0f0f};
        rows[13] = '{r_type(2, 1, 12, 0, 'h2a), 'hbfc00034, 'hf, 12, 'h00000001};
        rows[14] = '{r_type(2, 1, 13, 0, 'h2b), 'hbfc00038, 'hf, 13, 'h00000000};
        rows[15] = '{r_type(0, 1, 14, 4, 'h00), 'hbfc0003c, 'hf, 14, 'h23487650};
        rows[16] = '{r_type(0, 7, 15, 4, 'h02), 'hbfc00040, 'hf, 15, 'h0edcc698};
        rows[17] = '{r_type(0, 7, 16, 4, 'h03), 'hbfc00044, 'hf, 16, 'hfedcc698};
        rows[18] = '{i_type('h09, 0, 17, 'h0040), 'hbfc00048, 'hf, 17, 'h00000040};
        rows[19] = '{i_type('h2b, 17, 1, 'h0008), 'hbfc0004c, 'h0, 0, 'h0};  // SW
        rows[20] = '{i_type('h2b, 17, 7, 'h000c), 'hbfc00050, 'h0, 0, 'h0};
        rows[21] = '{i_type('h23, 17, 18, 'h0008), 'hbfc00054, 'hf, 18, 'h12348765};
        rows[22] = '{i_type('h23, 17, 19, 'h000c), 'hbfc00058, 'hf, 19, 'hedcc698b};
        rows[23] = '{i_type('h04, 18, 1, 'h0002), 'hbfc0005c, 'h0, 0, 'h0};  // Taken BEQ
        rows[24] = '{i_type('h05, 18, 1, 'h0005), 'hbfc00068, 'h0, 0, 'h0};
        rows[25] = '{jump_to('hbfc00080), 'hbfc0006c, 'h0, 0, 'h0};
        rows[26] = '{32'hfc000000, 'hbfc00080, 'h0, 0, 'h0};  // Unknown opcode
        rows[27] = '{i_type('h09, 18, 20, 'h0001), 'hbfc00084, 'hf, 20, 'h12348766};
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        row_errors++;
    endtask

    // **********************************************************************
    // Bus models give addr_ok after 0 to 3 cycles and data_ok 1 to 3 cycles later
    // **********************************************************************
    initial begin
        int unsigned delay;
        logic [31:0] req_addr;
        inst_addr_ok <= 1'b0;
        inst_data_ok <= 1'b0;
        inst_rdata   <= '0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            if (inst_req) begin
                delay = rand_below(4);
                repeat (delay) @(posedge clk);
                req_addr = inst_addr;
                inst_addr_ok <= 1'b1;
                @(posedge clk);
                inst_addr_ok <= 1'b0;
                delay = 1 + rand_below(3);
                repeat (delay - 1) @(posedge clk);
                inst_data_ok <= 1'b1;
                inst_rdata   <= rom_read(req_addr);
                @(posedge clk);
                inst_data_ok <= 1'b0;
            end
        end
    end

    initial begin
        int unsigned delay;
        logic [31:0] req_addr;
        data_addr_ok <= 1'b0;
        data_data_ok <= 1'b0;
        data_rdata   <= '0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            if (data_req) begin
                delay = rand_below(4);
                repeat (delay) @(posedge clk);
                req_addr = data_addr;
                if (data_wr) ram[req_addr[7:2]] = data_wdata;  // Store lands on acceptance
                data_addr_ok <= 1'b1;
                @(posedge clk);
                data_addr_ok <= 1'b0;
                delay = 1 + rand_below(3);
                repeat (delay - 1) @(posedge clk);
                data_data_ok <= 1'b1;
                data_rdata   <= ram[req_addr[7:2]];
                @(posedge clk);
                data_data_ok <= 1'b0;
            end
        end
    end

    // **********************************************************************
    // Trace checks against the table
    // **********************************************************************
    initial begin
        int pass_count;
        int fail_count;
        pass_count = 0;
        fail_count = 0;
        fill_table();
        for (int i = 0; i < rom_words; i++) rom[i] = fill_word(boot_pc + 4 * i);
        for (int i = 0; i < ram_words; i++) ram[i] = fill_word(4 * i);
        for (int i = 0; i < num_rows; i++) rom[(rows[i].pc - boot_pc) >> 2] = rows[i].word;
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            @(negedge clk);
            while (debug_wb_pc === 32'h0) @(negedge clk);  // Wait for the retire pulse
            row_errors = 0;
            if (debug_wb_pc !== rows[i].pc)
                report_mismatch("debug_wb_pc", rows[i].pc, debug_wb_pc);
            if (debug_wb_rf_wen !== rows[i].wen)
                report_mismatch("debug_wb_rf_wen", rows[i].wen, debug_wb_rf_wen);
            if (rows[i].wen != 4'h0 && debug_wb_rf_wnum !== rows[i].wnum)
                report_mismatch("debug_wb_rf_wnum", rows[i].wnum, debug_wb_rf_wnum);
            if (rows[i].wen != 4'h0 && debug_wb_rf_wdata !== rows[i].wdata)
                report_mismatch("debug_wb_rf_wdata", rows[i].wdata, debug_wb_rf_wdata);
            if (row_errors == 0) pass_count++;
            else                 fail_count++;
            $display("Row %0d at pc %h: %s", i, rows[i].pc, row_errors == 0 ? "ok" : "wrong");
        end
        $display("Rows checked: %0d ok, %0d wrong", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired at time %0t: the core stopped retiring instructions", $time);
        $display("sim failed");
        $finish;
    end

endmodule

// File: src/mips_core.sv
// MIPS32 core top level with instruction bus, data bus and debug trace ports
module mips_core #(
    parameter mips_pkg::addr_t reset_pc = 32'hbfc00000
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 inst_req,
    output mips_pkg::addr_t      inst_addr,
    input  logic                 inst_addr_ok,
    input  logic                 inst_data_ok,
    input  mips_pkg::word_t      inst_rdata,
    output logic                 data_req,
    output logic                 data_wr,
    output mips_pkg::addr_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,
    input  mips_pkg::word_t      data_rdata,
    output mips_pkg::addr_t      debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);
    import mips_pkg::*;

    logic       fetch_done, exec_done, writes_reg, redirect, rf_we, commit;
    addr_t      fetch_pc, exec_pc, redirect_target, next_pc;
    word_t      fetch_word, rs_data, rt_data, result, rf_wdata;
    creg_addr_t rs_addr, rt_addr, dest, rf_waddr;

    decoded_if dec_bus ();

    // ******************************************************************
    // One instruction travels fetch, decode, execute, write-back in turn
    // ******************************************************************
    inst_fetch #(.reset_pc(reset_pc)) inst_fetch_i (
        .clk, .rst, .commit, .next_pc, .inst_addr_ok, .inst_data_ok, .inst_rdata,
        .inst_req, .inst_addr, .fetch_done, .fetch_pc, .fetch_word
    );

    inst_decode inst_decode_i (
        .clk, .rst, .fetch_done, .fetch_pc, .fetch_word, .rs_data, .rt_data,
        .rs_addr, .rt_addr, .dec(dec_bus.producer)
    );

    alu_execute alu_execute_i (
        .clk, .rst, .data_addr_ok, .data_data_ok, .data_rdata, .dec(dec_bus.consumer),
        .data_req, .data_wr, .data_addr, .data_wdata, .exec_done, .writes_reg,
        .redirect, .result, .dest, .exec_pc, .redirect_target
    );

    wb_result wb_result_i (
        .clk, .rst, .exec_done, .writes_reg, .redirect, .result, .dest, .exec_pc,
        .redirect_target, .rf_we, .rf_waddr, .rf_wdata, .commit, .next_pc,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    reg_file reg_file_i (
        .clk, .rst, .rs_addr, .rt_addr, .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .rs_data, .rt_data
    );

endmodule

// File: src/reg_file.sv
// General-purpose register file, two read ports and one write port
module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  mips_pkg::creg_addr_t rs_addr,
    input  mips_pkg::creg_addr_t rt_addr,
    input  logic                 we,
    input  mips_pkg::creg_addr_t waddr,
    input  mips_pkg::word_t      wdata,
    output mips_pkg::word_t      rs_data,
    output mips_pkg::word_t      rt_data
);
    import mips_pkg::*;

    word_t regs [31:1];  // r0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: src/wb_result.sv
// Write-back unit: register write, debug trace and next-PC commit
module wb_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exec_done,
    input  logic                 writes_reg,
    input  logic                 redirect,
    input  mips_pkg::word_t      result,
    input  mips_pkg::creg_addr_t dest,
    input  mips_pkg::addr_t      exec_pc,
    input  mips_pkg::addr_t      redirect_target,
    output logic                 rf_we,
    output mips_pkg::creg_addr_t rf_waddr,
    output mips_pkg::word_t      rf_wdata,
    output logic                 commit,
    output mips_pkg::addr_t      next_pc,
    output mips_pkg::addr_t      debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);
    import mips_pkg::*;

    core_state_e state;
    logic        write_q;
    creg_addr_t  dest_q;
    word_t       result_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_exec;
            write_q     <= 1'b0;
            debug_wb_pc <= '0;
        end else begin
            state       <= exec_done ? st_commit : st_exec;
            write_q     <= exec_done && writes_reg && (dest != '0);  // r0 never written
            debug_wb_pc <= exec_done ? exec_pc : '0;  // Nonzero only in the retire cycle
        end
    end

    always_ff @(posedge clk) begin
        if (exec_done) begin
            dest_q   <= dest;
            result_q <= result;
            next_pc  <= redirect ? redirect_target : exec_pc + 32'd4;
        end
    end

    assign commit            = (state == st_commit);
    assign rf_we             = write_q;
    assign rf_waddr          = dest_q;
    assign rf_wdata          = result_q;
    assign debug_wb_rf_wen   = {4{write_q}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = result_q;

endmodule

// File: src/alu_execute.sv
// Execute unit: ALU, branch resolution and data-bus load/store sequencing
module alu_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,
    input  mips_pkg::word_t      data_rdata,
    decoded_if.consumer          dec,
    output logic                 data_req,
    output logic                 data_wr,
    output mips_pkg::addr_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    output logic                 exec_done,
    output logic                 writes_reg,
    output logic                 redirect,
    output mips_pkg::word_t      result,
    output mips_pkg::creg_addr_t dest,
    output mips_pkg::addr_t      exec_pc,
    output mips_pkg::addr_t      redirect_target
);
    import mips_pkg::*;

    core_state_e mem_state;
    word_t       alu_result;
    logic        is_mem;
    logic        taken;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_result = dec.src_a + dec.src_b;
            alu_sub:  alu_result = dec.src_a - dec.src_b;
            alu_and:  alu_result = dec.src_a & dec.src_b;
            alu_or:   alu_result = dec.src_a | dec.src_b;
            alu_xor:  alu_result = dec.src_a ^ dec.src_b;
            alu_nor:  alu_result = ~(dec.src_a | dec.src_b);
            alu_slt:  alu_result = {31'b0, $signed(dec.src_a) < $signed(dec.src_b)};
            alu_sltu: alu_result = {31'b0, dec.src_a < dec.src_b};
            alu_sll:  alu_result = dec.src_a << dec.src_b[4:0];
            alu_srl:  alu_result = dec.src_a >> dec.src_b[4:0];
            alu_sra:  alu_result = $signed(dec.src_a) >>> dec.src_b[4:0];
            alu_lui:  alu_result = dec.src_b;
            default:  alu_result = '0;
        endcase
    end

    assign is_mem = (dec.cls == cls_load) || (dec.cls == cls_store);
    assign taken  = (dec.cls == cls_jump) ||
                    ((dec.cls == cls_branch) && ((dec.src_a == dec.src_b) ^ dec.branch_ne));

    // ******************************************************************
    // Data-bus sequencing; data_req low inside st_mem means waiting for data
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_state <= st_exec;
            data_req  <= 1'b0;
            data_wr   <= 1'b0;
            exec_done <= 1'b0;
        end else begin
            exec_done <= 1'b0;
            if (mem_state == st_mem) begin
                if (data_req && data_addr_ok) begin
                    data_req <= 1'b0;
                    data_wr  <= 1'b0;
                end else if (!data_req && data_data_ok) begin
                    exec_done <= 1'b1;
                    mem_state <= st_exec;
                end
            end else if (dec.valid) begin
                if (is_mem) begin
                    mem_state <= st_mem;
                    data_req  <= 1'b1;
                    data_wr   <= (dec.cls == cls_store);
                end else begin
                    exec_done <= 1'b1;  // Everything else finishes in one cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            data_addr       <= alu_result;
            data_wdata      <= dec.store_data;
            result          <= alu_result;
            dest            <= dec.dest;
            writes_reg      <= dec.writes_reg;
            exec_pc         <= dec.pc;
            redirect        <= taken;
            redirect_target <= dec.target;
        end else if (mem_state == st_mem && !data_req && data_data_ok) begin
            result <= data_rdata;  // Store data is dropped by writes_reg low
        end
    end

endmodule

// File: src/inst_decode.sv
// Decode unit: field split, instruction classification, operand and
// destination selection, branch and jump target computation
module inst_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_done,
    input  mips_pkg::addr_t      fetch_pc,
    input  mips_pkg::word_t      fetch_word,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    output mips_pkg::creg_addr_t rs_addr,
    output mips_pkg::creg_addr_t rt_addr,
    decoded_if.producer          dec
);
    import mips_pkg::*;

    opcode_e      opcode;
    funct_e       funct;
    creg_addr_t   rd_addr;
    logic [4:0]   shamt;
    word_t        imm_sext;
    word_t        imm_zext;
    addr_t        pc_plus4;
    instr_class_e cls;
    alu_op_e      alu_op;
    word_t        src_a;
    word_t        src_b;
    creg_addr_t   dest;
    logic         writes_reg;
    addr_t        target;

    assign opcode   = opcode_e'(fetch_word[31:26]);
    assign funct    = funct_e'(fetch_word[5:0]);
    assign rs_addr  = fetch_word[25:21];
    assign rt_addr  = fetch_word[20:16];
    assign rd_addr  = fetch_word[15:11];
    assign shamt    = fetch_word[10:6];
    assign imm_sext = {{16{fetch_word[15]}}, fetch_word[15:0]};
    assign imm_zext = {16'b0, fetch_word[15:0]};
    assign pc_plus4 = fetch_pc + 32'd4;

    always_comb begin
        cls        = cls_alu;
        alu_op     = alu_add;
        src_a      = rs_data;
        src_b      = imm_sext;
        dest       = rt_addr;
        writes_reg = 1'b1;
        target     = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (opcode)
            op_special: begin
                src_b = rt_data;
                dest  = rd_addr;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    default: cls    = cls_invalid;
                endcase
                if (alu_op inside {alu_sll, alu_srl, alu_sra}) begin
                    src_a = rt_data;  // Shifts move rt by the shift amount
                    src_b = {27'b0, shamt};
                end
            end
            op_addiu: alu_op = alu_add;
            op_sltiu: alu_op = alu_sltu;
            op_andi: begin
                alu_op = alu_and;
                src_b  = imm_zext;
            end
            op_ori: begin
                alu_op = alu_or;
                src_b  = imm_zext;
            end
            op_xori: begin
                alu_op = alu_xor;
                src_b  = imm_zext;
            end
            op_lui: begin
                alu_op = alu_lui;
                src_b  = {fetch_word[15:0], 16'b0};
            end
            op_lw: cls = cls_load;
            op_sw: cls = cls_store;
            op_beq, op_bne: begin
                cls   = cls_branch;
                src_b = rt_data;  // Compared raw in execute
            end
            op_j: begin
                cls    = cls_jump;
                target = {pc_plus4[31:28], fetch_word[25:0], 2'b00};
            end
            default: cls = cls_invalid;
        endcase
        if (cls inside {cls_store, cls_branch, cls_jump, cls_invalid}) writes_reg = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) dec.valid <= 1'b0;
        else     dec.valid <= fetch_done;
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            dec.pc         <= fetch_pc;
            dec.cls        <= cls;
            dec.alu_op     <= alu_op;
            dec.src_a      <= src_a;
            dec.src_b      <= src_b;
            dec.store_data <= rt_data;
            dec.dest       <= dest;
            dec.writes_reg <= writes_reg;
            dec.branch_ne  <= (opcode == op_bne);
            dec.target     <= target;
        end
    end

endmodule

// File: src/inst_fetch.sv
// Fetch unit: PC register and instruction-bus request sequencing
module inst_fetch #(
    parameter mips_pkg::addr_t reset_pc = 32'hbfc00000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            commit,
    input  mips_pkg::addr_t next_pc,
    input  logic            inst_addr_ok,
    input  logic            inst_data_ok,
    input  mips_pkg::word_t inst_rdata,
    output logic            inst_req,
    output mips_pkg::addr_t inst_addr,
    output logic            fetch_done,
    output mips_pkg::addr_t fetch_pc,
    output mips_pkg::word_t fetch_word
);
    import mips_pkg::*;

    // st_fetch holds the request, st_decode waits for the word on its way to
    // decode, st_commit idles until the current instruction retires
    core_state_e state;
    addr_t       pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_fetch;  // First request goes out right after reset
            pc         <= reset_pc;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                st_fetch: begin
                    if (inst_addr_ok) state <= st_decode;
                end
                st_decode: begin
                    if (inst_data_ok) begin
                        fetch_done <= 1'b1;
                        state      <= st_commit;
                    end
                end
                default: begin
                    if (commit) begin
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode && inst_data_ok) fetch_word <= inst_rdata;
    end

    assign inst_req  = (state == st_fetch);
    assign inst_addr = pc;
    assign fetch_pc  = pc;  // PC stays put until the next commit

endmodule

// File: src/decoded_if.sv
// Decoded-instruction bundle passed from decode to execute
interface decoded_if;
    import mips_pkg::*;

    logic         valid;
    addr_t        pc;
    instr_class_e cls;
    alu_op_e      alu_op;
    word_t        src_a;
    word_t        src_b;
    word_t        store_data;
    creg_addr_t   dest;
    logic         writes_reg;
    logic         branch_ne;
    addr_t        target;

    modport producer (
        output valid, pc, cls, alu_op, src_a, src_b, store_data,
        output dest, writes_reg, branch_ne, target
    );

    modport consumer (
        input valid, pc, cls, alu_op, src_a, src_b, store_data,
        input dest, writes_reg, branch_ne, target
    );
endinterface

// File: src/mips_pkg.sv
// Shared MIPS32 core types: words, register numbers, opcode, funct and ALU
// operation enums, instruction classes and the sequencer state token
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  creg_addr_t;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        cls_alu, cls_load, cls_store, cls_branch, cls_jump, cls_invalid
    } instr_class_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_exec, st_mem, st_commit
    } core_state_e;

endpackage
